// ==== hw/pio_pkg.sv ====
`default_nettype none

package pio_pkg;

	// ******************************
	// bus and table sizes
	// ******************************
	localparam int pio_nbits        = 32; // host data bus.
	localparam int pio_addr_nbits   = 16; // host byte address.
	localparam int wmem_width       = 50; // one table entry.
	localparam int wmem_depth_nbits = 10; // 1024 entries.
	localparam int wmem_hi_nbits    = wmem_width - pio_nbits; // 18-bit upper part.

	// ******************************
	// address map
	// ******************************
	localparam logic [1:0] region_wmem = 2'd0; // addr[15:14] for the table.
	localparam logic [1:0] region_csr  = 2'd1; // addr[15:14] for the registers.
	localparam int csr_scratch_dw = 0; // scratch register.
	localparam int csr_count_dw   = 1; // app read counter.

	// host byte address in dword and qword views.
	typedef union packed {
		struct packed {
			logic [1:0]  region; // target region.
			logic [11:0] dw_idx; // bit 0 picks the high half.
			logic [1:0]  boff;   // byte in dword.
		} dw;
		struct packed {
			logic [1:0]  region; // same bits as dw.region.
			logic [10:0] qw_idx; // low 10 bits index the table.
			logic [2:0]  boff;   // byte in qword.
		} qw;
	} pio_addr_u;

endpackage

`default_nettype wire

// ==== hw/ram_1r1w.sv ====
`timescale 1ns/10ps
`default_nettype none

module ram_1r1w (
	input  wire logic                                 clk,
	input  wire logic                                 wr,
	input  wire logic [pio_pkg::wmem_depth_nbits-1:0] waddr,
	input  wire logic [pio_pkg::wmem_depth_nbits-1:0] raddr,
	input  wire logic [pio_pkg::wmem_width-1:0]       din,
	output logic      [pio_pkg::wmem_width-1:0]       dout
);

	localparam int depth = 1 << pio_pkg::wmem_depth_nbits; // 1024 entries.

	logic [pio_pkg::wmem_width-1:0] mem [depth]; // table storage.

	// write port.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din; // full 50-bit entry.
		end
	end

	// read port returns old data on a same-cycle write.
	always_ff @(posedge clk) begin
		dout <= mem[raddr]; // one cycle latency.
	end

endmodule

`default_nettype wire

// ==== hw/pio_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module pio_decode (
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic [pio_pkg::pio_addr_nbits-1:0] reg_addr,
	input  wire logic [pio_pkg::pio_nbits-1:0]      reg_din,
	input  wire logic                               reg_rd,
	input  wire logic                               reg_wr,
	output logic                                    sel_rd,
	output logic                                    sel_wr,
	output logic                                    wmem_ms,
	output logic                                    csr_ms,
	output logic                                    none_ms,
	output pio_pkg::pio_addr_u                      dec_addr,
	output logic      [pio_pkg::pio_nbits-1:0]      dec_din
);

	logic access;   // any strobe this cycle.
	logic wmem_hit; // address falls in the table.
	logic csr_hit;  // address is a live register.

	// ******************************
	// input registers
	// ******************************
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_rd <= 1'b0;
			sel_wr <= 1'b0;
		end else begin
			sel_rd <= reg_rd; // one-cycle pulse.
			sel_wr <= reg_wr; // one-cycle pulse.
		end
	end

	always_ff @(posedge clk) begin
		dec_addr <= reg_addr; // address and data for the targets.
		dec_din  <= reg_din;
	end

	// ******************************
	// target select
	// ******************************
	assign access   = sel_rd | sel_wr;
	assign wmem_hit = dec_addr.dw.region == pio_pkg::region_wmem;
	// both registers live in qword 0 and higher offsets go unmapped.
	assign csr_hit  = (dec_addr.dw.region == pio_pkg::region_csr) &&
	                  (dec_addr.qw.qw_idx == '0);

	assign wmem_ms = access & wmem_hit; // table access.
	assign csr_ms  = access & csr_hit;  // register access.
	assign none_ms = access & ~wmem_hit & ~csr_hit; // regions 2/3 and holes.

endmodule

`default_nettype wire

// ==== hw/pio_wmem.sv ====
`timescale 1ns/10ps
`default_nettype none

module pio_wmem (
	input  wire logic                                 clk,
	input  wire logic                                 reset,
	input  wire logic                                 sel_rd,
	input  wire logic                                 sel_wr,
	input  wire logic                                 wmem_ms,
	input  wire pio_pkg::pio_addr_u                   dec_addr,
	input  wire logic [pio_pkg::pio_nbits-1:0]        dec_din,
	input  wire logic                                 app_mem_rd,
	input  wire logic [pio_pkg::wmem_depth_nbits-1:0] app_mem_raddr,
	output logic                                      wmem_done,
	output logic      [pio_pkg::pio_nbits-1:0]        wmem_rdata,
	output logic                                      app_mem_ack,
	output logic      [pio_pkg::wmem_width-1:0]       app_mem_rdata
);

	localparam int nbits = pio_pkg::pio_nbits;
	localparam int hbits = pio_pkg::wmem_hi_nbits;
	localparam int dbits = pio_pkg::wmem_depth_nbits;

	logic             hi_half;     // dword index bit 0.
	logic             wr_lo;       // stage low dword.
	logic             wr_hi;       // commit full entry.
	logic             rd_lo;       // low read select.
	logic             rd_hi;       // high read select.
	logic             rd_lo_go;    // low read takes the RAM this cycle.
	logic             rd_lo_d1;    // RAM output holds the low read.
	logic             rd_save;     // low read blocked by the app port.
	logic             app_rd_d1;   // app pipe stage 1, owns raddr.
	logic             app_rd_d2;   // app pipe stage 2, RAM output valid.
	logic [dbits-1:0] app_raddr_d1;
	logic [dbits-1:0] ram_raddr;
	logic [dbits-1:0] entry_idx;   // table index from the qword view.
	logic [nbits-1:0] wdata_lo;    // staged low dword.
	logic [hbits-1:0] rdata_hi;    // upper part of the last low read.
	logic [pio_pkg::wmem_width-1:0] ram_wdata;
	logic [pio_pkg::wmem_width-1:0] ram_rdata;

	// ******************************
	// host access decode
	// ******************************
	assign hi_half   = dec_addr.dw.dw_idx[0];
	assign entry_idx = dec_addr.qw.qw_idx[dbits-1:0];

	assign wr_lo = wmem_ms & sel_wr & ~hi_half;
	assign wr_hi = wmem_ms & sel_wr & hi_half;
	assign rd_lo = wmem_ms & sel_rd & ~hi_half;
	assign rd_hi = wmem_ms & sel_rd & hi_half;

	// app stage 1 wins the read address.
	assign rd_lo_go  = ~app_rd_d1 & (rd_lo | rd_save);
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : entry_idx;
	assign ram_wdata = {dec_din[hbits-1:0], wdata_lo}; // upper din bits dropped.

	// ******************************
	// control
	// ******************************
	always_ff @(posedge clk) begin
		if (reset) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_mem_ack <= 1'b0;
			rd_lo_d1 <= 1'b0;
			rd_save <= 1'b0;
			wmem_done <= 1'b0;
		end else begin
			app_rd_d1 <= app_mem_rd;
			app_rd_d2 <= app_rd_d1;
			app_mem_ack <= app_rd_d2; // 3 cycles after app_mem_rd.
			rd_lo_d1 <= rd_lo_go;
			// held until the RAM takes the read.
			rd_save <= (rd_lo & app_rd_d1) | (rd_save & ~rd_lo_go);
			wmem_done <= wr_lo | wr_hi | rd_hi | rd_lo_d1;
		end
	end

	// ******************************
	// data path
	// ******************************
	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_mem_raddr;
		app_mem_rdata <= ram_rdata; // app result.
		if (wr_lo) begin
			wdata_lo <= dec_din; // staged until the high write.
		end
		if (rd_lo_d1) begin
			rdata_hi <= ram_rdata[pio_pkg::wmem_width-1:nbits]; // for the high read.
		end
		if (rd_lo_d1) begin
			wmem_rdata <= ram_rdata[nbits-1:0];
		end else if (rd_hi) begin
			wmem_rdata <= {{(nbits-hbits){1'b0}}, rdata_hi}; // zero-extended.
		end else begin
			wmem_rdata <= '0; // writes return zero.
		end
	end

	ram_1r1w ram_1r1w_inst (
		.clk   (clk),
		.wr    (wr_hi),
		.waddr (entry_idx),
		.raddr (ram_raddr),
		.din   (ram_wdata),
		.dout  (ram_rdata)
	);

endmodule

`default_nettype wire

// ==== hw/pio_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

module pio_csr (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          sel_rd,
	input  wire logic                          sel_wr,
	input  wire logic                          csr_ms,
	input  wire pio_pkg::pio_addr_u            dec_addr,
	input  wire logic [pio_pkg::pio_nbits-1:0] dec_din,
	input  wire logic                          app_mem_ack,
	output logic                               csr_done,
	output logic      [pio_pkg::pio_nbits-1:0] csr_rdata
);

	logic                          is_scratch; // offset picks scratch.
	logic                          is_count;   // offset picks the counter.
	logic                          wr_scratch;
	logic                          clr_count;  // any write to the counter.
	logic [pio_pkg::pio_nbits-1:0] scratch;
	logic [pio_pkg::pio_nbits-1:0] count;      // served app reads.

	assign is_scratch = dec_addr.dw.dw_idx == 12'(pio_pkg::csr_scratch_dw);
	assign is_count   = dec_addr.dw.dw_idx == 12'(pio_pkg::csr_count_dw);
	assign wr_scratch = csr_ms & sel_wr & is_scratch;
	assign clr_count  = csr_ms & sel_wr & is_count;

	// ******************************
	// registers
	// ******************************
	always_ff @(posedge clk) begin
		if (reset) begin
			scratch <= '0;
			count <= '0;
		end else begin
			if (wr_scratch) begin
				scratch <= dec_din;
			end
			if (clr_count) begin
				count <= '0; // clear beats a count.
			end else if (app_mem_ack) begin
				count <= count + 1'b1; // wraps.
			end
		end
	end

	// ******************************
	// completion
	// ******************************
	always_ff @(posedge clk) begin
		if (reset) begin
			csr_done <= 1'b0;
		end else begin
			csr_done <= csr_ms; // one cycle after the select.
		end
	end

	always_ff @(posedge clk) begin
		if (csr_ms & sel_rd & is_scratch) begin
			csr_rdata <= scratch;
		end else if (csr_ms & sel_rd & is_count) begin
			csr_rdata <= count; // value before this cycle's count.
		end else begin
			csr_rdata <= '0; // writes return zero.
		end
	end

endmodule

`default_nettype wire

// ==== hw/pio_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module pio_result (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          clk_div,
	input  wire logic                          wmem_done,
	input  wire logic [pio_pkg::pio_nbits-1:0] wmem_rdata,
	input  wire logic                          csr_done,
	input  wire logic [pio_pkg::pio_nbits-1:0] csr_rdata,
	input  wire logic                          none_ms,
	output logic                               mem_ack,
	output logic      [pio_pkg::pio_nbits-1:0] mem_rdata
);

	logic                          none_done; // unmapped access completes.
	logic                          done_any;  // some target finished.
	logic                          pending;   // done seen, ack not yet raised.
	logic [pio_pkg::pio_nbits-1:0] done_data;
	logic [pio_pkg::pio_nbits-1:0] pend_data;

	assign done_any = wmem_done | csr_done | none_done;

	// one target finishes per access, unmapped gives zero.
	assign done_data = wmem_done ? wmem_rdata :
	                   csr_done  ? csr_rdata  : '0;

	// ******************************
	// ack alignment to clk_div
	// ******************************
	always_ff @(posedge clk) begin
		if (reset) begin
			none_done <= 1'b0;
			pending <= 1'b0;
			mem_ack <= 1'b0;
		end else begin
			none_done <= none_ms; // one cycle after the select.
			if (done_any) begin
				pending <= 1'b1;
			end else if (clk_div) begin
				pending <= 1'b0; // moved into mem_ack.
			end
			if (clk_div) begin
				mem_ack <= pending; // rises, then falls on the next enable.
			end
		end
	end

	// ******************************
	// read data
	// ******************************
	always_ff @(posedge clk) begin
		if (done_any) begin
			pend_data <= done_data;
		end
		if (clk_div & pending) begin
			mem_rdata <= pend_data; // stable while mem_ack is high.
		end
	end

endmodule

`default_nettype wire

// ==== hw/pio_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module pio_subsys (
	input  wire logic                                 clk,
	input  wire logic                                 reset,
	input  wire logic                                 clk_div,
	input  wire logic [pio_pkg::pio_addr_nbits-1:0]   reg_addr,
	input  wire logic [pio_pkg::pio_nbits-1:0]        reg_din,
	input  wire logic                                 reg_rd,
	input  wire logic                                 reg_wr,
	input  wire logic                                 app_mem_rd,
	input  wire logic [pio_pkg::wmem_depth_nbits-1:0] app_mem_raddr,
	output logic                                      mem_ack,
	output logic      [pio_pkg::pio_nbits-1:0]        mem_rdata,
	output logic                                      app_mem_ack,
	output logic      [pio_pkg::wmem_width-1:0]       app_mem_rdata
);

	logic                          sel_rd;   // registered host read.
	logic                          sel_wr;   // registered host write.
	logic                          wmem_ms;  // table select.
	logic                          csr_ms;   // register select.
	logic                          none_ms;  // unmapped select.
	pio_pkg::pio_addr_u            dec_addr;
	logic [pio_pkg::pio_nbits-1:0] dec_din;
	logic                          wmem_done;
	logic [pio_pkg::pio_nbits-1:0] wmem_rdata;
	logic                          csr_done;
	logic [pio_pkg::pio_nbits-1:0] csr_rdata;

	// ******************************
	// decode
	// ******************************
	pio_decode pio_decode_inst (
		.clk      (clk),
		.reset    (reset),
		.reg_addr (reg_addr),
		.reg_din  (reg_din),
		.reg_rd   (reg_rd),
		.reg_wr   (reg_wr),
		.sel_rd   (sel_rd),
		.sel_wr   (sel_wr),
		.wmem_ms  (wmem_ms),
		.csr_ms   (csr_ms),
		.none_ms  (none_ms),
		.dec_addr (dec_addr),
		.dec_din  (dec_din)
	);

	// ******************************
	// execute
	// ******************************
	pio_wmem pio_wmem_inst (
		.clk           (clk),
		.reset         (reset),
		.sel_rd        (sel_rd),
		.sel_wr        (sel_wr),
		.wmem_ms       (wmem_ms),
		.dec_addr      (dec_addr),
		.dec_din       (dec_din),
		.app_mem_rd    (app_mem_rd),
		.app_mem_raddr (app_mem_raddr),
		.wmem_done     (wmem_done),
		.wmem_rdata    (wmem_rdata),
		.app_mem_ack   (app_mem_ack),
		.app_mem_rdata (app_mem_rdata)
	);

	pio_csr pio_csr_inst (
		.clk         (clk),
		.reset       (reset),
		.sel_rd      (sel_rd),
		.sel_wr      (sel_wr),
		.csr_ms      (csr_ms),
		.dec_addr    (dec_addr),
		.dec_din     (dec_din),
		.app_mem_ack (app_mem_ack), // counts served app reads.
		.csr_done    (csr_done),
		.csr_rdata   (csr_rdata)
	);

	// ******************************
	// result
	// ******************************
	pio_result pio_result_inst (
		.clk        (clk),
		.reset      (reset),
		.clk_div    (clk_div),
		.wmem_done  (wmem_done),
		.wmem_rdata (wmem_rdata),
		.csr_done   (csr_done),
		.csr_rdata  (csr_rdata),
		.none_ms    (none_ms),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== tb/tb_pio_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pio_subsys;

	localparam int n_fill          = 1024; // every table entry.
	localparam int n_check         = 64;   // random read-backs.
	localparam int n_rewrite       = 32;   // write then read at random indices.
	localparam int n_mixed         = 24;   // host read pairs during app traffic.
	localparam int n_unmapped      = 8;
	localparam int host_accesses   = 2 * n_fill + 2 * n_check + 4 * n_rewrite +
	                                 2 * n_mixed + 4 * n_unmapped + 16;
	localparam int watchdog_cycles = host_accesses * 40 + 2000;
	localparam int ack_timeout     = 100; // cycles allowed per host access.

	logic        clk;
	logic        reset;
	logic        clk_div;
	logic [15:0] reg_addr;
	logic [31:0] reg_din;
	logic        reg_rd;
	logic        reg_wr;
	logic        app_mem_rd;
	logic [9:0]  app_mem_raddr;
	logic        mem_ack;
	logic [31:0] mem_rdata;
	logic        app_mem_ack;
	logic [49:0] app_mem_rdata;

	logic [1:0]  div_cnt;      // clk_div phase.
	logic [15:0] lfsr;         // random state.
	int          value_errors;
	int          other_errors;
	int          cyc;          // negedge count.
	logic        prev_ack;
	logic        prev_div;
	int          app_due [$];  // cycle each app result is due.
	logic [49:0] app_exp [$];  // expected app data, same order.

	// ******************************
	// reference model state
	// ******************************
	logic [49:0] model_mem [1024];
	logic [31:0] staged_lo;     // last low dword written.
	logic [17:0] saved_hi;      // upper part from the last low read.
	logic [31:0] model_scratch;
	logic [31:0] model_count;   // app reads since the last clear.

	pio_subsys pio_subsys_inst (
		.clk           (clk),
		.reset         (reset),
		.clk_div       (clk_div),
		.reg_addr      (reg_addr),
		.reg_din       (reg_din),
		.reg_rd        (reg_rd),
		.reg_wr        (reg_wr),
		.app_mem_rd    (app_mem_rd),
		.app_mem_raddr (app_mem_raddr),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.app_mem_ack   (app_mem_ack),
		.app_mem_rdata (app_mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	always @(posedge clk) begin
		if (reset) begin
			div_cnt <= 2'd0;
			clk_div <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 2'd1;
			clk_div <= (div_cnt == 2'd3); // one cycle in four.
		end
	end

	// ******************************
	// helpers
	// ******************************
	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit.
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] lo_addr(input logic [9:0] idx);
		return {2'd0, 1'b0, idx, 3'd0}; // region 0, qword index.
	endfunction

	function automatic logic [15:0] csr_addr(input logic [11:0] dw);
		return {2'd1, dw, 2'd0};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		value_errors++;
	endtask

	task automatic model_write(input logic [15:0] addr, input logic [31:0] data);
		if (addr[15:14] == 2'd0) begin
			if (addr[2]) begin
				model_mem[addr[12:3]] = {data[17:0], staged_lo}; // upper din dropped.
			end else begin
				staged_lo = data;
			end
		end else if (addr[15:14] == 2'd1) begin
			if (addr[13:2] == 12'd0) begin
				model_scratch = data;
			end else if (addr[13:2] == 12'd1) begin
				model_count = '0; // any write clears.
			end
		end
	endtask

	task automatic model_read(input logic [15:0] addr, output logic [31:0] exp);
		exp = '0; // unmapped reads give zero.
		if (addr[15:14] == 2'd0) begin
			if (addr[2]) begin
				exp = {14'd0, saved_hi};
			end else begin
				exp = model_mem[addr[12:3]][31:0];
				saved_hi = model_mem[addr[12:3]][49:32];
			end
		end else if (addr[15:14] == 2'd1) begin
			if (addr[13:2] == 12'd0) begin
				exp = model_scratch;
			end else if (addr[13:2] == 12'd1) begin
				exp = model_count;
			end
		end
	endtask

	// one strobe, then wait for the ack to rise and fall.
	task automatic host_access(input logic is_wr, input logic [15:0] addr,
			input logic [31:0] din, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata = '0;
		@(posedge clk);
		reg_addr <= addr;
		reg_din <= din;
		reg_wr <= is_wr;
		reg_rd <= ~is_wr;
		@(posedge clk);
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
		@(negedge clk);
		while (mem_ack !== 1'b1 && waited < ack_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (mem_ack !== 1'b1) begin
			$display("host access to %h got no ack at %0t", addr, $time);
			other_errors++;
		end else begin
			rdata = mem_rdata; // stable while the ack is high.
			waited = 0;
			while (mem_ack !== 1'b0 && waited < ack_timeout) begin
				@(negedge clk);
				waited++;
			end
			if (mem_ack !== 1'b0) begin
				$display("mem_ack stuck high after access to %h", addr);
				other_errors++;
			end
		end
	endtask

	task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] dummy;
		host_access(1'b1, addr, data, dummy);
		model_write(addr, data);
	endtask

	task automatic read_check(input logic [15:0] addr);
		logic [31:0] got;
		logic [31:0] exp;
		model_read(addr, exp);
		host_access(1'b0, addr, 32'h0, got);
		if (got !== exp) begin
			report_mismatch("mem_rdata", 64'(got), 64'(exp));
		end
	endtask

	task automatic app_burst(input int n, input logic dense);
		int i;
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			app_mem_rd <= dense ? 1'b1 : (rand_bits(2) != 32'd0); // 3/4 busy when sparse.
			app_mem_raddr <= 10'(rand_bits(10));
		end
		@(posedge clk);
		app_mem_rd <= 1'b0;
	endtask

	task automatic app_drain();
		int waited;
		waited = 0;
		while (app_due.size() > 0 && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (app_due.size() > 0) begin
			$display("app results still missing after the burst");
			other_errors++;
		end
	endtask

	// ******************************
	// output monitor
	// ******************************
	always @(negedge clk) begin
		cyc++;
		if (reset) begin
			prev_ack = 1'b0;
			prev_div = 1'b0;
		end else begin
			if (mem_ack !== prev_ack && prev_div !== 1'b1) begin
				$display("mem_ack changed at %0t without clk_div before it", $time);
				other_errors++;
			end
			prev_ack = mem_ack;
			prev_div = clk_div;
			if (app_due.size() > 0 && app_due[0] == cyc) begin
				if (app_mem_ack !== 1'b1) begin
					report_mismatch("app_mem_ack", 64'(app_mem_ack), 64'd1);
				end
				if (app_mem_rdata !== app_exp[0]) begin
					report_mismatch("app_mem_rdata", 64'(app_mem_rdata), 64'(app_exp[0]));
				end
				void'(app_due.pop_front());
				void'(app_exp.pop_front());
			end else if (app_mem_ack !== 1'b0) begin
				report_mismatch("app_mem_ack", 64'(app_mem_ack), 64'd0);
			end
			if (app_mem_rd === 1'b1) begin
				app_due.push_back(cyc + 3); // fixed 3-cycle latency.
				app_exp.push_back(model_mem[app_mem_raddr]);
				model_count++;
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$finish;
	end

	// ******************************
	// test sequence
	// ******************************
	initial begin
		logic [9:0]  idx;
		logic [11:0] dw;
		logic [15:0] addr;
		int          i;
		reset = 1'b1;
		clk_div = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		app_mem_rd = 1'b0;
		app_mem_raddr = '0;
		lfsr = 16'd91;
		value_errors = 0;
		other_errors = 0;
		cyc = 0;
		staged_lo = '0;
		saved_hi = '0;
		model_scratch = '0;
		model_count = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (mem_ack !== 1'b0) begin
			report_mismatch("mem_ack", 64'(mem_ack), 64'd0);
		end
		if (app_mem_ack !== 1'b0) begin
			report_mismatch("app_mem_ack", 64'(app_mem_ack), 64'd0);
		end
		for (i = 0; i < n_fill; i++) begin
			host_write(lo_addr(10'(i)), rand_bits(32));
			host_write(lo_addr(10'(i)) | 16'd4, rand_bits(32)); // junk upper bits.
		end
		for (i = 0; i < n_check; i++) begin
			idx = 10'(rand_bits(10));
			read_check(lo_addr(idx));
			read_check(lo_addr(idx) | 16'd4);
		end
		for (i = 0; i < n_rewrite; i++) begin
			idx = 10'(rand_bits(10));
			host_write(lo_addr(idx), rand_bits(32));
			host_write(lo_addr(idx) | 16'd4, rand_bits(32));
			read_check(lo_addr(idx));
			read_check(lo_addr(idx) | 16'd4);
		end
		for (i = 0; i < 4; i++) begin
			app_burst(64, 1'b1); // back to back.
			app_drain();
		end
		fork
			app_burst(300, 1'b0);
			begin
				for (i = 0; i < n_mixed; i++) begin
					idx = 10'(rand_bits(10));
					read_check(lo_addr(idx)); // may be deferred.
					read_check(lo_addr(idx) | 16'd4);
				end
			end
		join
		app_drain();
		read_check(csr_addr(12'd1)); // all app reads since reset.
		host_write(csr_addr(12'd0), rand_bits(32));
		read_check(csr_addr(12'd0));
		host_write(csr_addr(12'd1), rand_bits(32)); // clears the counter.
		read_check(csr_addr(12'd1));
		app_burst(20, 1'b1);
		app_drain();
		read_check(csr_addr(12'd1));
		for (i = 0; i < n_unmapped; i++) begin
			dw = 12'(rand_bits(12));
			if (i % 4 == 0) begin
				addr = {2'd2, dw, 2'd0};
			end else if (i % 4 == 1) begin
				addr = {2'd3, dw, 2'd0};
			end else begin
				addr = csr_addr((dw < 12'd2) ? 12'd2 : dw); // register holes.
			end
			host_write(addr, rand_bits(32));
			read_check(addr);
			read_check(lo_addr(addr[12:3])); // table entry with the same index.
			read_check(lo_addr(addr[12:3]) | 16'd4);
		end
		read_check(csr_addr(12'd0));
		read_check(csr_addr(12'd1));
		$display("errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/pio_pkg.sv
hw/ram_1r1w.sv
hw/pio_decode.sv
hw/pio_wmem.sv
hw/pio_csr.sv
hw/pio_result.sv
hw/pio_subsys.sv
tb/tb_pio_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_pio_subsys \
	-f verilog.f \
	-o tb_pio_subsys

./obj_dir/tb_pio_subsys | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	exit 0
else
	exit 1
fi
